// ==== Bender.yml ====
package:
  name: bus_subsystem

sources:
  # Packages first, then RTL
  - files:
      - bus_pkg.sv
      - uart_pkg.sv
      - block_ram.sv
      - sram_port.sv
      - uart.sv
      - bus_decode.sv
      - system_top.sv
  # Testbench, top module tb_top
  - target: simulation
    files:
      - tb_clock.sv
      - system_assert.sv
      - tb_top.sv

// ==== block_ram.sv ====
// Synchronous on-chip block RAM with registered read
`timescale 1ns/10ps

module block_ram
   import bus_pkg::*;
#(
   parameter int ADDR_BITS = RAM_ADDR_W
)
(
   input  logic                 clk,
   input  logic                 cs,
   input  logic                 write,
   input  logic [ADDR_BITS-1:0] addr,
   input  logic [DATA_W-1:0]    wdata,
   output logic [DATA_W-1:0]    rdata
);

   // Storage array, one word per address
   logic [DATA_W-1:0] mem [0:(1<<ADDR_BITS)-1];

   // One access per cycle, write or read
   always_ff @(posedge clk)
   begin
      if (cs)
      begin
         if (write)
            mem[addr] <= wdata;
         else
            // Read data lands one edge after select
            rdata <= mem[addr];
      end
   end

endmodule

// ==== build.f ====
bus_pkg.sv
uart_pkg.sv
block_ram.sv
sram_port.sv
uart.sv
bus_decode.sv
system_top.sv
tb_clock.sv
system_assert.sv
tb_top.sv

// ==== bus_decode.sv ====
// Address decoder with target selects, read pipeline and return data mux
`timescale 1ns/10ps

module bus_decode
   import bus_pkg::*;
(
   input  logic              clk,
   input  logic              reset_b,
   // Master side
   input  logic              req_valid,
   input  logic              rnw,
   input  logic [ADDR_W-1:0] addr,
   input  logic [DATA_W-1:0] wdata,
   output logic [DATA_W-1:0] rdata,
   output logic              rdata_valid,
   // Target side, stage 1
   output logic [ADDR_W-1:0] t_addr,
   output logic [DATA_W-1:0] t_wdata,
   output logic              t_write,
   output logic              ram_cs,
   output logic              uart_cs,
   output logic              sram_cs,
   // Target read data, valid in stage 2
   input  logic [DATA_W-1:0] ram_rdata,
   input  logic [DATA_W-1:0] uart_rdata,
   input  logic [DATA_W-1:0] sram_rdata
);

   logic                    uart_hit;
   logic                    ram_hit;
   logic [TAG_W-1:0]        s1_tag;
   logic [TAG_W-1:0]        s2_tag;
   logic [READ_LATENCY-1:0] rd_pipe;

   // UART pair ignores address bit 0
   assign uart_hit = (addr[ADDR_W-1:1] == UART_BASE[ADDR_W-1:1]);

   // RAM mirrored at bottom and top of the map
   assign ram_hit = (addr[ADDR_W-1:RAM_ADDR_W] == '0) ||
                    (addr[ADDR_W-1:RAM_ADDR_W] == '1);

   // Stage 1 selects, UART wins over the top RAM window
   always_ff @(posedge clk)
   begin
      if (!reset_b)
      begin
         uart_cs <= 1'b0;
         ram_cs  <= 1'b0;
         sram_cs <= 1'b0;
         t_write <= 1'b0;
      end
      else
      begin
         uart_cs <= req_valid & uart_hit;
         ram_cs  <= req_valid & ~uart_hit & ram_hit;
         sram_cs <= req_valid & ~uart_hit & ~ram_hit;
         t_write <= req_valid & ~rnw;
      end
   end

   // Shared address and write data, held between requests
   always_ff @(posedge clk)
   begin
      if (req_valid)
      begin
         t_addr  <= addr;
         t_wdata <= wdata;
      end
   end

   // Tag of the target selected in stage 1
   always_comb
   begin
      if (uart_cs)
         s1_tag = TAG_UART;
      else if (ram_cs)
         s1_tag = TAG_RAM;
      else
         s1_tag = TAG_SRAM;
   end

   // Tag follows its read into stage 2
   always_ff @(posedge clk)
   begin
      s2_tag <= s1_tag;
   end

   // One bit per cycle of read latency
   always_ff @(posedge clk)
   begin
      if (!reset_b)
         rd_pipe <= '0;
      else
         rd_pipe <= {rd_pipe[READ_LATENCY-2:0], req_valid & rnw};
   end

   assign rdata_valid = rd_pipe[READ_LATENCY-1];

   // Return mux, steered by the tag of the read now completing
   always_comb
   begin
      case (s2_tag)
         TAG_UART: rdata = uart_rdata;
         TAG_RAM:  rdata = ram_rdata;
         default:  rdata = sram_rdata;
      endcase
   end

endmodule

// ==== bus_pkg.sv ====
// Bus widths, address map, read latency and target tag codes
package bus_pkg;

   // Master bus widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 16;

   // Block RAM window size in address bits
   // RAM answers when upper bits are all zero or all one
   localparam int RAM_ADDR_W = 12;

   // UART register pair, bit 0 picks status or data
   localparam logic [ADDR_W-1:0] UART_BASE = 16'hFE08;

   // External SRAM address pins, top bits held at zero
   localparam int SRAM_ADR_W = 18;

   // Cycles from accepted read to returned data
   localparam int READ_LATENCY = 2;

   // Target tag carried alongside a read to the return mux
   localparam int TAG_W = 2;
   localparam logic [TAG_W-1:0] TAG_SRAM = 2'd0;
   localparam logic [TAG_W-1:0] TAG_RAM  = 2'd1;
   localparam logic [TAG_W-1:0] TAG_UART = 2'd2;

endpackage

// ==== sram_port.sv ====
// External asynchronous SRAM pin driver with tristate data bus
`timescale 1ns/10ps

module sram_port
   import bus_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset_b,
   input  logic                  cs,
   input  logic                  write,
   input  logic [ADDR_W-1:0]     addr,
   input  logic [DATA_W-1:0]     wdata,
   output logic [DATA_W-1:0]     rdata,
   // Pins
   output logic                  ram_we_b,
   output logic                  ram_oe_b,
   output logic                  ram_cs_b,
   output logic [SRAM_ADR_W-1:0] ram_adr,
   inout  wire  [DATA_W-1:0]     ram_dat
);

   // Active low enable of the data pin driver
   logic              dat_oe_b;
   logic [DATA_W-1:0] dat_out;

   // Chip always enabled, as on the board
   assign ram_cs_b = 1'b0;

   // Strobes for one cycle after the select
   always_ff @(posedge clk)
   begin
      if (!reset_b)
      begin
         ram_we_b <= 1'b1;
         ram_oe_b <= 1'b1;
         dat_oe_b <= 1'b1;
      end
      else
      begin
         ram_we_b <= ~(cs & write);
         ram_oe_b <= ~(cs & ~write);
         // Drive only during the write strobe, no contention
         dat_oe_b <= ~(cs & write);
      end
   end

   // Pin address and data, zero-extended to the SRAM width
   always_ff @(posedge clk)
   begin
      if (cs)
      begin
         ram_adr <= SRAM_ADR_W'(addr);
         dat_out <= wdata;
      end
   end

   assign ram_dat = dat_oe_b ? {DATA_W{1'bz}} : dat_out;

   // Pins read back during the ram_oe_b cycle, taken by the master at its end
   assign rdata = ram_dat;

endmodule

// ==== system_assert.sv ====
// Concurrent checks on target selects, read latency and SRAM strobes, with their bind statements
`timescale 1ns/10ps

module system_assert
(
   input logic       clk,
   input logic       reset_b,
   input logic [2:0] sel,
   input logic       rd_req,
   input logic       rd_ret,
   input logic       we_b,
   input logic       oe_b,
   input logic       dat_oe_b
);

   // Read by the testbench top at the end of the run
   int fail_count = 0;

   // No more than one target selected in a cycle
   sel_onehot: assert property (@(posedge clk) disable iff (!reset_b) $onehot0(sel))
   else
   begin
      fail_count = fail_count + 1;
      $error("more than one target select high");
   end

   // Read data returns exactly two edges after the request
   read_latency: assert property (@(posedge clk) disable iff (!reset_b)
                                  rd_ret == $past(rd_req, 2))
   else
   begin
      fail_count = fail_count + 1;
      $error("rdata_valid out of step with read request");
   end

   // Data pins driven only during the write strobe
   drive_with_we: assert property (@(posedge clk) disable iff (!reset_b) we_b == dat_oe_b)
   else
   begin
      fail_count = fail_count + 1;
      $error("data driver enable differs from ram_we_b");
   end

   // Write and output strobes never overlap
   strobe_excl: assert property (@(posedge clk) disable iff (!reset_b) we_b | oe_b)
   else
   begin
      fail_count = fail_count + 1;
      $error("ram_we_b and ram_oe_b low together");
   end

endmodule

// Decoder side, SRAM strobes tied idle
bind bus_decode system_assert decode_chk_i (
   .clk      (clk),
   .reset_b  (reset_b),
   .sel      ({ram_cs, uart_cs, sram_cs}),
   .rd_req   (req_valid & rnw),
   .rd_ret   (rdata_valid),
   .we_b     (1'b1),
   .oe_b     (1'b1),
   .dat_oe_b (1'b1)
);

// SRAM pin side, bus checks tied idle
bind sram_port system_assert pin_chk_i (
   .clk      (clk),
   .reset_b  (reset_b),
   .sel      (3'b000),
   .rd_req   (1'b0),
   .rd_ret   (1'b0),
   .we_b     (ram_we_b),
   .oe_b     (ram_oe_b),
   .dat_oe_b (dat_oe_b)
);

// ==== system_top.sv ====
// Top level of the bus subsystem: decoder, block RAM, UART and SRAM port
`timescale 1ns/10ps

module system_top
   import bus_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset_b,
   // Master request
   input  logic                  req_valid,
   input  logic                  rnw,
   input  logic [ADDR_W-1:0]     addr,
   input  logic [DATA_W-1:0]     wdata,
   // Read return
   output logic [DATA_W-1:0]     rdata,
   output logic                  rdata_valid,
   // External SRAM pins
   output logic                  ram_we_b,
   output logic                  ram_oe_b,
   output logic                  ram_cs_b,
   output logic [SRAM_ADR_W-1:0] ram_adr,
   inout  wire  [DATA_W-1:0]     ram_dat,
   // Serial line
   input  logic                  rxd,
   output logic                  txd
);

   // Registered request shared by all targets
   logic [ADDR_W-1:0] t_addr;
   logic [DATA_W-1:0] t_wdata;
   logic              t_write;

   // One select per target
   logic              ram_cs;
   logic              uart_cs;
   logic              sram_cs;

   // Per-target read data, one register deep
   logic [DATA_W-1:0] ram_rdata;
   logic [DATA_W-1:0] uart_rdata;
   logic [DATA_W-1:0] sram_rdata;

   bus_decode u_decode (
      .clk         (clk),
      .reset_b     (reset_b),
      .req_valid   (req_valid),
      .rnw         (rnw),
      .addr        (addr),
      .wdata       (wdata),
      .rdata       (rdata),
      .rdata_valid (rdata_valid),
      .t_addr      (t_addr),
      .t_wdata     (t_wdata),
      .t_write     (t_write),
      .ram_cs      (ram_cs),
      .uart_cs     (uart_cs),
      .sram_cs     (sram_cs),
      .ram_rdata   (ram_rdata),
      .uart_rdata  (uart_rdata),
      .sram_rdata  (sram_rdata)
   );

   // Low address bits only, so both windows alias
   block_ram #(.ADDR_BITS(RAM_ADDR_W)) u_ram (
      .clk   (clk),
      .cs    (ram_cs),
      .write (t_write),
      .addr  (t_addr[RAM_ADDR_W-1:0]),
      .wdata (t_wdata),
      .rdata (ram_rdata)
   );

   uart u_uart (
      .clk     (clk),
      .reset_b (reset_b),
      .cs      (uart_cs),
      .write   (t_write),
      .reg_sel (t_addr[0]),
      .wdata   (t_wdata),
      .rdata   (uart_rdata),
      .rxd     (rxd),
      .txd     (txd)
   );

   sram_port u_sram (
      .clk      (clk),
      .reset_b  (reset_b),
      .cs       (sram_cs),
      .write    (t_write),
      .addr     (t_addr),
      .wdata    (t_wdata),
      .rdata    (sram_rdata),
      .ram_we_b (ram_we_b),
      .ram_oe_b (ram_oe_b),
      .ram_cs_b (ram_cs_b),
      .ram_adr  (ram_adr),
      .ram_dat  (ram_dat)
   );

endmodule

// ==== tb_clock.sv ====
// Free-running testbench clock source
`timescale 1ns/10ps

module tb_clock
(
   output logic clk
);

   // Half of the 100 ns period
   localparam int HALF_PERIOD = 50;

   // Starts low, first rising edge at 50 ns
   initial
   begin
      clk = 1'b0;
      forever
         #HALF_PERIOD clk = ~clk;
   end

endmodule

// ==== tb_top.sv ====
// Testbench top: random bus stimulus, RAM/SRAM/UART reference models, SRAM pin model, checks
`timescale 1ns/10ps

module tb_top
   import bus_pkg::*;
   import uart_pkg::*;
();

   // Cycle limits for the wait loops
   localparam int RET_LIMIT  = 20;
   localparam int POLL_LIMIT = 100;

   logic                  clk;
   logic                  reset_b;
   logic                  req_valid;
   logic                  rnw;
   logic [ADDR_W-1:0]     addr;
   logic [DATA_W-1:0]     wdata;
   logic [DATA_W-1:0]     rdata;
   logic                  rdata_valid;
   logic                  ram_we_b;
   logic                  ram_oe_b;
   logic                  ram_cs_b;
   logic [SRAM_ADR_W-1:0] ram_adr;
   wire  [DATA_W-1:0]     ram_dat;
   // txd looped back to rxd
   wire                   serial_line;

   // Reference models and SRAM chip contents
   logic [DATA_W-1:0]     ram_ref [0:(1<<RAM_ADDR_W)-1];
   logic [DATA_W-1:0]     sram_ref [0:(1<<ADDR_W)-1];
   logic [DATA_W-1:0]     sram_cells [0:(1<<ADDR_W)-1];
   logic [ADDR_W-1:0]     ram_used [$];
   // Outstanding reads, in issue order
   logic [DATA_W-1:0]     exp_data [$];
   bit                    exp_chk [$];
   logic [DATA_W-1:0]     last_rdata;
   logic [1:0]            rd_hist;

   tb_clock clk_gen (.clk(clk));

   system_top dut_i (
      .clk         (clk),
      .reset_b     (reset_b),
      .req_valid   (req_valid),
      .rnw         (rnw),
      .addr        (addr),
      .wdata       (wdata),
      .rdata       (rdata),
      .rdata_valid (rdata_valid),
      .ram_we_b    (ram_we_b),
      .ram_oe_b    (ram_oe_b),
      .ram_cs_b    (ram_cs_b),
      .ram_adr     (ram_adr),
      .ram_dat     (ram_dat),
      .rxd         (serial_line),
      .txd         (serial_line)
   );

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      if (got !== want)
         stop_run($sformatf("ERR %s got %h expected %h", name, got, want));
   endtask

   // Initial SRAM contents, odd multiplier keeps every word distinct
   function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
      return DATA_W'(a * 16'h9E37) ^ 16'h5A5A;
   endfunction

   // Address map as seen by the master
   function automatic bit is_uart(input logic [ADDR_W-1:0] a);
      return a[ADDR_W-1:1] == UART_BASE[ADDR_W-1:1];
   endfunction

   function automatic bit in_ram(input logic [ADDR_W-1:0] a);
      return !is_uart(a) && (a[ADDR_W-1:RAM_ADDR_W] == '0 || a[ADDR_W-1:RAM_ADDR_W] == '1);
   endfunction

   function automatic void model_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
      if (in_ram(a))
         ram_ref[a[RAM_ADDR_W-1:0]] = d;
      else if (!is_uart(a))
         sram_ref[a] = d;
   endfunction

   function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] a);
      if (in_ram(a))
         return ram_ref[a[RAM_ADDR_W-1:0]];
      return sram_ref[a];
   endfunction

   task automatic write_word(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
      @(posedge clk);
      req_valid <= 1'b1;
      rnw       <= 1'b0;
      addr      <= a;
      wdata     <= d;
      model_write(a, d);
   endtask

   // Issue one read, expected value taken from the model now
   task automatic read_word(input logic [ADDR_W-1:0] a, input bit chk);
      @(posedge clk);
      req_valid <= 1'b1;
      rnw       <= 1'b1;
      addr      <= a;
      wdata     <= DATA_W'($urandom);
      exp_data.push_back(model_read(a));
      exp_chk.push_back(chk);
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      req_valid <= 1'b0;
   endtask

   task automatic drain_reads();
      int count;
      count = 0;
      while (exp_data.size() != 0)
      begin
         if (count == RET_LIMIT)
            stop_run("Timeout waiting for read data to return");
         @(posedge clk);
         count++;
      end
   endtask

   // Single read whose value the caller inspects
   task automatic read_value(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] d);
      read_word(a, 1'b0);
      idle_cycle();
      drain_reads();
      d = last_rdata;
   endtask

   task automatic poll_status(input int bit_pos, input logic want);
      logic [DATA_W-1:0] s;
      int                n;
      n = 0;
      read_value(UART_BASE, s);
      while (s[bit_pos] !== want)
      begin
         if (n == POLL_LIMIT)
            stop_run($sformatf("Timeout polling UART status bit %0d", bit_pos));
         read_value(UART_BASE, s);
         n++;
      end
   endtask

   // SRAM chip on the pins, stores in mid-cycle of the write strobe
   assign ram_dat = ram_oe_b ? {DATA_W{1'bz}} : sram_cells[ram_adr[ADDR_W-1:0]];

   always @(negedge clk)
   begin
      if (ram_we_b === 1'b0)
         sram_cells[ram_adr[ADDR_W-1:0]] = ram_dat;
      if (ram_we_b === 1'b0 || ram_oe_b === 1'b0)
      begin
         check_value("ram_adr_high", ram_adr[SRAM_ADR_W-1:ADDR_W], 0);
         check_value("ram_cs_b", ram_cs_b, 0);
      end
   end

   // Return monitor, mid-cycle where outputs are stable
   always @(negedge clk)
   begin
      logic [DATA_W-1:0] e;
      bit                c;
      if (reset_b)
      begin
         check_value("rdata_valid", rdata_valid, rd_hist[1]);
         if (rdata_valid)
         begin
            if (exp_data.size() == 0)
               stop_run("Read data returned with no read outstanding");
            e = exp_data.pop_front();
            c = exp_chk.pop_front();
            if (c)
               check_value("rdata", rdata, e);
            last_rdata = rdata;
         end
      end
      // Request seen now returns two negedges later
      rd_hist = {rd_hist[0], req_valid & rnw};
   end

   // Mixed writes and reads in the bottom window
   task automatic random_ram_access();
      logic [ADDR_W-1:0] a;
      for (int i = 0; i < 64; i++)
      begin
         if (ram_used.size() == 0 || $urandom % 2 == 0)
         begin
            a = ADDR_W'($urandom % (1 << RAM_ADDR_W));
            write_word(a, DATA_W'($urandom));
            ram_used.push_back(a);
         end
         else
            read_word(ram_used[$urandom % ram_used.size()], 1'b1);
      end
      idle_cycle();
      drain_reads();
   endtask

   // Top and bottom windows share the low address bits
   task automatic mirror_windows();
      logic [RAM_ADDR_W-1:0] off;
      logic [ADDR_W-1:0]     top;
      logic [ADDR_W-1:0]     bot;
      for (int i = 0; i < 8; i++)
      begin
         off = RAM_ADDR_W'($urandom);
         top = {{(ADDR_W-RAM_ADDR_W){1'b1}}, off};
         // Step off the UART pair
         if (is_uart(top))
            top = top ^ 16'h0100;
         bot = {{(ADDR_W-RAM_ADDR_W){1'b0}}, top[RAM_ADDR_W-1:0]};
         write_word(top, DATA_W'($urandom));
         read_word(bot, 1'b1);
         write_word(bot, DATA_W'($urandom));
         read_word(top, 1'b1);
         ram_used.push_back(bot);
      end
      idle_cycle();
      drain_reads();
   endtask

   function automatic logic [ADDR_W-1:0] sram_addr();
      return {4'(1 + ($urandom % 14)), 12'($urandom)};
   endfunction

   // Outside both windows, then RAM must still hold its data
   task automatic external_sram_access();
      logic [ADDR_W-1:0] a;
      logic [ADDR_W-1:0] written [$];
      for (int i = 0; i < 48; i++)
      begin
         a = sram_addr();
         if ($urandom % 2 == 0)
         begin
            write_word(a, DATA_W'($urandom));
            written.push_back(a);
         end
         else
            read_word(a, 1'b1);
      end
      // Written words come back through the pins
      foreach (written[i])
         read_word(written[i], 1'b1);
      foreach (ram_used[i])
         read_word(ram_used[i], 1'b1);
      idle_cycle();
      drain_reads();
   endtask

   // RAM and SRAM reads on consecutive cycles
   task automatic alternating_reads();
      for (int i = 0; i < 16; i++)
      begin
         read_word(ram_used[$urandom % ram_used.size()], 1'b1);
         read_word(sram_addr(), 1'b1);
      end
      idle_cycle();
      drain_reads();
   endtask

   task automatic uart_loopback();
      logic [7:0]        b;
      logic [DATA_W-1:0] d;
      poll_status(STAT_TX_BUSY, 1'b0);
      b = 8'($urandom);
      // Upper bits of the data word are ignored
      write_word(UART_BASE | 16'h0001, {8'($urandom), b});
      idle_cycle();
      poll_status(STAT_RX_VALID, 1'b1);
      read_value(UART_BASE | 16'h0001, d);
      check_value("uart_rx_data", d, {8'h00, b});
      read_value(UART_BASE, d);
      check_value("uart_rx_valid", d[STAT_RX_VALID], 0);
   endtask

   task automatic uart_busy_drop();
      logic [7:0]        first;
      logic [DATA_W-1:0] d;
      poll_status(STAT_TX_BUSY, 1'b0);
      first = 8'($urandom);
      write_word(UART_BASE | 16'h0001, {8'h00, first});
      idle_cycle();
      poll_status(STAT_TX_BUSY, 1'b1);
      // Second byte lands while the frame is going out
      write_word(UART_BASE | 16'h0001, {8'h00, ~first});
      idle_cycle();
      poll_status(STAT_RX_VALID, 1'b1);
      read_value(UART_BASE | 16'h0001, d);
      check_value("uart_rx_data", d, {8'h00, first});
      poll_status(STAT_TX_BUSY, 1'b0);
      // No second frame may arrive
      for (int i = 0; i < FRAME_BITS * CLKS_PER_BIT / 2; i++)
      begin
         read_value(UART_BASE, d);
         check_value("uart_rx_valid", d[STAT_RX_VALID], 0);
      end
   endtask

   initial
   begin
      // Fixed seed for the whole run
      void'($urandom(77));
      reset_b   = 1'b0;
      req_valid = 1'b0;
      rnw       = 1'b1;
      addr      = '0;
      wdata     = '0;
      rd_hist   = 2'b00;
      for (int i = 0; i < (1 << ADDR_W); i++)
      begin
         sram_cells[i] = fill_word(ADDR_W'(i));
         sram_ref[i]   = fill_word(ADDR_W'(i));
      end
      repeat (2) @(posedge clk);
      reset_b <= 1'b1;
      @(posedge clk);
      check_value("rdata_valid", rdata_valid, 0);
      check_value("ram_we_b", ram_we_b, 1);
      check_value("ram_oe_b", ram_oe_b, 1);
      check_value("ram_cs_b", ram_cs_b, 0);
      check_value("txd", serial_line, 1);

      random_ram_access();
      mirror_windows();
      external_sram_access();
      alternating_reads();
      uart_loopback();
      uart_busy_drop();

      if (dut_i.u_decode.decode_chk_i.fail_count + dut_i.u_sram.pin_chk_i.fail_count == 0)
      begin
         $display("Test OK");
         $finish;
      end
      else
         stop_run("Concurrent assertion failures during the run");
   end

endmodule

// ==== uart.sv ====
// Memory-mapped UART: status and data registers, transmitter and receiver
`timescale 1ns/10ps

module uart
   import bus_pkg::*;
   import uart_pkg::*;
(
   input  logic              clk,
   input  logic              reset_b,
   input  logic              cs,
   input  logic              write,
   input  logic              reg_sel,
   input  logic [DATA_W-1:0] wdata,
   output logic [DATA_W-1:0] rdata,
   input  logic              rxd,
   output logic              txd
);

   // Register access strobes
   logic                  data_wr;
   logic                  data_rd;
   logic                  reg_rd;
   logic [DATA_W-1:0]     status;

   // Transmitter
   logic                  tx_busy;
   logic [FRAME_BITS-1:0] tx_shift;
   logic [TICK_W-1:0]     tx_tick;
   logic [BIT_W-1:0]      tx_bit;

   // Receiver
   logic [1:0]            rx_sync;
   logic                  rx_active;
   logic [TICK_W-1:0]     rx_tick;
   logic [BIT_W-1:0]      rx_bit;
   logic [DATA_BITS-1:0]  rx_shift;
   logic [DATA_BITS-1:0]  rx_data;
   logic                  rx_valid;

   assign data_wr = cs & write & reg_sel;
   assign data_rd = cs & ~write & reg_sel;
   assign reg_rd  = cs & ~write;

   always_comb
   begin
      status                = '0;
      status[STAT_TX_BUSY]  = tx_busy;
      status[STAT_RX_VALID] = rx_valid;
   end

   // Register read, one edge after select
   always_ff @(posedge clk)
   begin
      if (reg_rd)
         rdata <= reg_sel ? DATA_W'(rx_data) : status;
   end

   // Line idles high, LSB of the shifter is the line
   assign txd = tx_shift[0];

   // Transmit frame LSB first, writes while busy are dropped
   always_ff @(posedge clk)
   begin
      if (!reset_b)
      begin
         tx_busy  <= 1'b0;
         tx_shift <= '1;
         tx_tick  <= '0;
         tx_bit   <= '0;
      end
      else if (tx_busy)
      begin
         if (tx_tick == TICK_W'(CLKS_PER_BIT - 1))
         begin
            tx_tick  <= '0;
            tx_shift <= {1'b1, tx_shift[FRAME_BITS-1:1]};
            if (tx_bit == BIT_W'(FRAME_BITS - 1))
               tx_busy <= 1'b0;
            else
               tx_bit <= tx_bit + 1'b1;
         end
         else
            tx_tick <= tx_tick + 1'b1;
      end
      else if (data_wr)
      begin
         // Stop, data, start
         tx_shift <= {1'b1, wdata[DATA_BITS-1:0], 1'b0};
         tx_busy  <= 1'b1;
         tx_tick  <= '0;
         tx_bit   <= '0;
      end
   end

   // Double synchronizer on the serial input
   always_ff @(posedge clk)
   begin
      if (!reset_b)
         rx_sync <= 2'b11;
      else
         rx_sync <= {rx_sync[0], rxd};
   end

   // Receive state, sampling at the middle of each bit
   always_ff @(posedge clk)
   begin
      if (!reset_b)
      begin
         rx_active <= 1'b0;
         rx_tick   <= '0;
         rx_bit    <= '0;
         rx_valid  <= 1'b0;
      end
      else
      begin
         // Data read consumes the byte
         if (data_rd)
            rx_valid <= 1'b0;
         if (!rx_active)
         begin
            if (!rx_sync[1])
            begin
               // Start edge, first sample half a bit on
               rx_active <= 1'b1;
               rx_tick   <= TICK_W'(CLKS_PER_BIT / 2);
               rx_bit    <= '0;
            end
         end
         else if (rx_tick == TICK_W'(CLKS_PER_BIT - 1))
         begin
            rx_tick <= '0;
            rx_bit  <= rx_bit + 1'b1;
            if (rx_bit == '0 && rx_sync[1])
               // Glitch, not a real start bit
               rx_active <= 1'b0;
            else if (rx_bit == BIT_W'(FRAME_BITS - 1))
            begin
               rx_active <= 1'b0;
               rx_valid  <= 1'b1;
            end
         end
         else
            rx_tick <= rx_tick + 1'b1;
      end
   end

   // Data bits shift in LSB first, byte held at the stop bit
   always_ff @(posedge clk)
   begin
      if (rx_active && rx_tick == TICK_W'(CLKS_PER_BIT - 1))
      begin
         if (rx_bit != '0 && rx_bit != BIT_W'(FRAME_BITS - 1))
            rx_shift <= {rx_sync[1], rx_shift[DATA_BITS-1:1]};
         if (rx_bit == BIT_W'(FRAME_BITS - 1))
            rx_data <= rx_shift;
      end
   end

endmodule

// ==== uart_pkg.sv ====
// UART bit timing, frame length, counter widths and status bit positions
package uart_pkg;

   // Clock cycles per serial bit
   localparam int CLKS_PER_BIT = 16;

   // Start bit, eight data bits, stop bit
   localparam int FRAME_BITS = 10;
   localparam int DATA_BITS  = FRAME_BITS - 2;

   // Counter widths for bit timing and bit position
   localparam int TICK_W = $clog2(CLKS_PER_BIT);
   localparam int BIT_W  = $clog2(FRAME_BITS);

   // Status register layout
   localparam int STAT_TX_BUSY  = 0;
   localparam int STAT_RX_VALID = 1;

endpackage
